//--- Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing -Wno-fatal
TOP       := tb_top
FILE_LIST := build.f
LOG       := sim.log

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

//--- bench/tb_checker.sv
`timescale 1ns/1ns
`include "mcu_params.svh"

module tb_checker (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  logic [7:0]          i_prog [0:`LOAD_BYTES-1],
   input  logic                i_code_wr,
   input  logic [`CODE_AW-1:0] i_code_addr,
   input  logic [7:0]          i_code_data,
   input  logic                i_uart_tx,
   output logic                o_done,
   output int                  o_writes,
   output int                  o_frames,
   output int                  o_wr_errs,
   output int                  o_tx_errs
);

   localparam int CPB = `CLKS_PER_BIT;

   logic [7:0] code [0:`LOAD_BYTES-1];   // program as the DUT stored it
   logic [7:0] exp_q [$];                // accumulator at each MOVX to the transmitter
   logic       model_ready = 1'b0;
   logic       done_q = 1'b0;
   int         sjmp_addr = -1;
   int         n_writes = 0;
   int         n_frames = 0;
   int         wr_errs = 0;
   int         tx_errs = 0;
   logic       rx_busy = 1'b0;
   int         rx_cnt = 0;
   int         bit_idx;
   logic [7:0] rx_byte;

   assign o_done    = done_q;
   assign o_writes  = n_writes;
   assign o_frames  = n_frames;
   assign o_wr_errs = wr_errs;
   assign o_tx_errs = tx_errs;

   task automatic show_mismatch(input string name, input int got, input int exp);
      $display("error at %0t: %s got %0h expected %0h", $time, name, got, exp);
   endtask

   task automatic show_fault(input string msg);
      $display("failure at %0t: %s", $time, msg);
   endtask

   ////////////////////////////////////////
   // instruction model, runs once the program is in

   task automatic run_model();
      logic [7:0]  a;
      logic [7:0]  op;
      logic [7:0]  imm;
      logic [7:0]  r [0:7];
      logic [15:0] dp;
      logic        c;
      logic        jump;
      logic        fin;
      int          pc;
      int          len;
      int          rel;
      int          t;
      int          steps;
      int          i;
      a = 8'd0;
      c = 1'b0;
      dp = 16'd0;
      pc = 0;
      steps = 0;
      fin = 1'b0;
      for (i = 0; i < 8; i++) r[i] = 8'd0;
      while (!fin && pc < `LOAD_BYTES && steps < 4 * `LOAD_BYTES) begin
         op = code[pc];
         imm = code[(pc + 1) % `LOAD_BYTES];
         rel = {{24{imm[7]}}, imm};
         len = 1;
         jump = 1'b0;
         casez (op)
            8'h74: begin a = imm; len = 2; end
            8'h24: begin t = a + imm; c = (t > 255); a = t[7:0]; len = 2; end
            8'h94: begin t = a - imm - c; c = (t < 0); a = t[7:0]; len = 2; end   // borrow
            8'h54: begin a = a & imm; len = 2; end
            8'h44: begin a = a | imm; len = 2; end
            8'h64: begin a = a ^ imm; len = 2; end
            8'h04: a = a + 8'd1;
            8'h14: a = a - 8'd1;
            8'hF4: a = ~a;
            8'hE4: a = 8'd0;
            8'h23: a = {a[6:0], a[7]};
            8'h33: {c, a} = {a, c};
            8'h13: {a, c} = {c, a};
            8'hC3: c = 1'b0;
            8'hD3: c = 1'b1;
            8'b11111???: r[op[2:0]] = a;
            8'b11101???: a = r[op[2:0]];
            8'b00101???: begin t = a + r[op[2:0]]; c = (t > 255); a = t[7:0]; end
            8'b00001???: r[op[2:0]] = r[op[2:0]] + 8'd1;
            8'b11011???: begin
               r[op[2:0]] = r[op[2:0]] - 8'd1;
               jump = (r[op[2:0]] != 8'd0);
               len = 2;
            end
            8'h80: begin
               fin = (imm == 8'hFE);   // sjmp to itself ends the program
               jump = 1'b1;
               len = 2;
            end
            8'h60: begin jump = (a == 8'd0); len = 2; end
            8'h70: begin jump = (a != 8'd0); len = 2; end
            8'h40: begin jump = c; len = 2; end
            8'h50: begin jump = !c; len = 2; end
            8'h90: begin dp = {imm, code[(pc + 2) % `LOAD_BYTES]}; len = 3; end
            8'hF0: if (dp == `TX_DPTR) exp_q.push_back(a);
            default: ;   // no-op
         endcase
         if (!fin) pc = jump ? pc + len + rel : pc + len;
         steps++;
      end
      if (fin) begin
         sjmp_addr = pc;
      end else begin
         show_fault("instruction model did not reach the closing SJMP");
         wr_errs++;
      end
      model_ready = 1'b1;
   endtask

   ////////////////////////////////////////
   // code writes

   always @(negedge i_clk) begin
      if (i_nrst && i_code_wr) begin
         if (n_writes >= `LOAD_BYTES) begin
            show_fault("code write after the load had finished");
            wr_errs++;
         end else begin
            if (int'(i_code_addr) != n_writes) begin
               show_mismatch("o_code_addr", int'(i_code_addr), n_writes);
               wr_errs++;
            end
            if (i_code_data != i_prog[n_writes]) begin
               show_mismatch("o_code_data", int'(i_code_data), int'(i_prog[n_writes]));
               wr_errs++;
            end
            code[n_writes] = i_code_data;
            if (n_writes == `LOAD_BYTES - 1) run_model();
         end
         n_writes++;
      end
   end

   ////////////////////////////////////////
   // serial output, sampled mid bit

   always @(negedge i_clk) begin
      if (!i_nrst) begin
         rx_busy = 1'b0;
      end else if (!rx_busy) begin
         if (!i_uart_tx) begin
            rx_busy = 1'b1;
            rx_cnt = 0;
            if (!model_ready) begin
               show_fault("o_uart_tx went low before the program was loaded");
               tx_errs++;
            end
         end
      end else begin
         rx_cnt++;
         if (rx_cnt % CPB == CPB / 2) begin
            bit_idx = rx_cnt / CPB;
            if (bit_idx == 0 && i_uart_tx) begin
               show_mismatch("o_uart_tx start bit", 1, 0);
               tx_errs++;
               rx_busy = 1'b0;
            end else if (bit_idx >= 1 && bit_idx <= 8) begin
               rx_byte[bit_idx - 1] = i_uart_tx;   // lsb first
            end else if (bit_idx == 9) begin
               if (!i_uart_tx) begin
                  show_mismatch("o_uart_tx stop bit", 0, 1);
                  tx_errs++;
               end
               if (n_frames >= exp_q.size()) begin
                  show_fault("more frames on o_uart_tx than the model predicts");
                  tx_errs++;
               end else if (rx_byte != exp_q[n_frames]) begin
                  show_mismatch("o_uart_tx byte", int'(rx_byte), int'(exp_q[n_frames]));
                  tx_errs++;
               end
               n_frames++;
               rx_busy = 1'b0;
            end
         end
      end
      // all frames seen and the core parked on its last SJMP
      if (model_ready && !rx_busy && n_frames == exp_q.size() &&
          int'(i_code_addr) == sjmp_addr) done_q = 1'b1;
   end

endmodule

//--- bench/tb_top.sv
`timescale 1ns/1ns
`include "mcu_params.svh"

module tb_top;

   localparam int CPB         = `CLKS_PER_BIT;
   localparam int EXTRA_BYTES = 4;   // sent after the load, loader must ignore them
   localparam int LOAD_CYC    = (`LOAD_BYTES + EXTRA_BYTES) * 14 * CPB;   // frame plus longest idle gap
   localparam int LIMIT       = LOAD_CYC + 400 * `LOAD_BYTES;

   localparam logic [7:0] IMM_OPS [0:5] = '{8'h74, 8'h24, 8'h94, 8'h54, 8'h44, 8'h64};
   localparam logic [7:0] ACC_OPS [0:8] = '{8'h04, 8'h14, 8'hF4, 8'hE4, 8'h23,
                                            8'h33, 8'h13, 8'hC3, 8'hD3};
   localparam logic [7:0] REG_OPS [0:3] = '{8'hF8, 8'hE8, 8'h28, 8'h08};
   localparam logic [7:0] BR_OPS  [0:5] = '{8'h80, 8'h60, 8'h70, 8'h40, 8'h50, 8'hD8};

   logic                clk;
   logic                nrst;
   logic                uart_rx;
   logic                uart_tx;
   logic                code_wr;
   logic [`CODE_AW-1:0] code_addr;
   logic [7:0]          code_wdata;
   logic [7:0]          code_rdata;
   logic [7:0]          code_mem [0:(1 << `CODE_AW) - 1];
   logic [7:0]          prog [0:`LOAD_BYTES-1];
   logic                done;
   int                  writes;
   int                  frames;
   int                  wr_errs;
   int                  tx_errs;
   int                  seed;
   int                  pos;
   int                  cycles = 0;
   int                  i;

   mcu_top u_dut (.i_clk(clk), .i_nrst(nrst), .i_uart_rx(uart_rx), .i_code_data(code_rdata),
      .o_uart_tx(uart_tx), .o_code_wr(code_wr), .o_code_addr(code_addr),
      .o_code_data(code_wdata));

   tb_checker u_chk (.i_clk(clk), .i_nrst(nrst), .i_prog(prog), .i_code_wr(code_wr),
      .i_code_addr(code_addr), .i_code_data(code_wdata), .i_uart_tx(uart_tx), .o_done(done),
      .o_writes(writes), .o_frames(frames), .o_wr_errs(wr_errs), .o_tx_errs(tx_errs));

   initial clk = 1'b0;
   always #50 clk = ~clk;

   // code memory with async read
   assign code_rdata = code_mem[code_addr];
   always @(posedge clk) if (code_wr) code_mem[code_addr] <= code_wdata;

   initial begin : fill_mem
      int a;
      for (a = 0; a < (1 << `CODE_AW); a++) code_mem[a] <= 8'(a) ^ 8'(a >> 8);
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", LIMIT);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // random program

   function automatic int rnd(input int n);
      return {$random(seed)} % n;
   endfunction

   task automatic put(input logic [7:0] b);
      prog[pos] = b;
      pos++;
   endtask

   task automatic emit_simple();
      int pick;
      pick = rnd(16);
      case (pick)
         0: begin put(8'hF0); put(8'hF0); end   // back to back movx
         1, 2, 3: put(8'hF0);
         4: begin
            put(8'h90);
            if (rnd(2) == 0) begin put(8'h03); put(8'h00); end   // off the transmitter
            else begin put(8'(`TX_DPTR >> 8)); put(8'(`TX_DPTR)); end
         end
         5, 6, 7, 8, 9: begin put(IMM_OPS[rnd(6)]); put(8'(rnd(256))); end
         10, 11, 12: put(ACC_OPS[rnd(9)]);
         default: put(REG_OPS[rnd(4)] | 8'(rnd(8)));
      endcase
   endtask

   // forward branch over whole instructions only
   task automatic emit_branch();
      int at;
      int k;
      k = rnd(6);
      put(BR_OPS[k] | ((k == 5) ? 8'(rnd(8)) : 8'h00));
      at = pos;
      put(8'h00);
      k = rnd(3);
      repeat (k) emit_simple();
      prog[at] = 8'(pos - at - 1);
   endtask

   task automatic build_program();
      pos = 0;
      put(8'h90);
      put(8'(`TX_DPTR >> 8));
      put(8'(`TX_DPTR));
      while (pos < `LOAD_BYTES - 10) begin   // leaves room for the largest block
         if (rnd(5) == 0) emit_branch();
         else emit_simple();
      end
      while (pos < `LOAD_BYTES - 2) put(8'h00);
      put(8'h80);
      put(8'hFE);   // sjmp to itself
   endtask

   ////////////////////////////////////////
   // serial driver for 8N1 frames lsb first

   task automatic send_bit(input logic v);
      @(posedge clk);
      uart_rx <= v;
      repeat (CPB - 1) @(posedge clk);
   endtask

   task automatic send_byte(input logic [7:0] b);
      int n;
      send_bit(1'b0);
      for (n = 0; n < 8; n++) send_bit(b[n]);
      send_bit(1'b1);
      repeat (rnd(4) * CPB) @(posedge clk);   // idle gap
   endtask

   initial begin
      seed = 18343;
      nrst = 1'b0;
      uart_rx = 1'b1;
      build_program();
      repeat (2) @(posedge clk);
      nrst <= 1'b1;
      for (i = 0; i < `LOAD_BYTES; i++) send_byte(prog[i]);
      for (i = 0; i < EXTRA_BYTES; i++) send_byte(8'(rnd(256)));   // core already running
      while (!done) @(posedge clk);
      repeat (12 * CPB) @(posedge clk);   // one frame time to catch a stray frame
      $display("code writes %0d with %0d errors, frames %0d with %0d errors",
               writes, wr_errs, frames, tx_errs);
      if (wr_errs == 0 && tx_errs == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- build.f
+incdir+src
src/mcu_pkg.sv
src/uart_rx.sv
src/code_loader.sv
src/fetch_decode.sv
src/execute.sv
src/uart_tx.sv
src/mcu_top.sv
bench/tb_checker.sv
bench/tb_top.sv

//--- src/code_loader.sv
`timescale 1ns/1ns
`include "mcu_params.svh"

module code_loader (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  logic [7:0]          i_byte,
   input  logic                i_byte_valid,
   input  logic [`CODE_AW-1:0] i_fetch_addr,
   output logic                o_code_wr,
   output logic [`CODE_AW-1:0] o_code_addr,
   output logic [7:0]          o_code_data,
   output logic                o_load_done
);

   localparam logic [`CODE_AW-1:0] LAST = `LOAD_BYTES - 1;

   logic [`CODE_AW-1:0] count;   // bytes written so far

   assign o_code_wr   = i_byte_valid & ~o_load_done;
   assign o_code_data = i_byte;
   assign o_code_addr = o_load_done ? i_fetch_addr : count;   // core owns the bus after load

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         count       <= '0;
         o_load_done <= 1'b0;
      end else if (o_code_wr) begin
         count <= count + 1'b1;
         if (count == LAST) o_load_done <= 1'b1;
      end
   end

endmodule

//--- src/execute.sv
`timescale 1ns/1ns
`include "mcu_params.svh"

module execute import mcu_pkg::*; (
   input  logic    i_clk,
   input  logic    i_nrst,
   input  instr_s  i_instr,
   input  logic    i_instr_valid,
   input  logic    i_tx_ready,
   output logic    o_exec_done,
   output branch_s o_branch,
   output tx_req_s o_tx
);

   op_word_u        op;
   logic [7:0]      acc;
   logic [7:0]      acc_nx;
   logic            carry;
   logic            c_nx;
   logic [7:0][7:0] regs;     // r0..r7
   logic [15:0]     dptr;
   logic [7:0]      r_sel;
   logic [7:0]      r_dec;
   logic [7:0]      r_nx;
   logic            r_wr;
   logic [8:0]      sum;
   logic [8:0]      diff;
   logic            taken;
   logic            movx_tx;
   logic            pend;     // transmit request still waiting

   assign op    = i_instr.op;
   assign r_sel = regs[op.g.rn];
   assign r_dec = r_sel - 1'b1;

   ////////////////////////////////////////
   // alu

   assign sum  = {1'b0, acc} + {1'b0, (op.g.grp == GRP_ADDAR) ? r_sel : i_instr.op1};
   assign diff = {1'b0, acc} - {1'b0, i_instr.op1} - {8'd0, carry};   // bit 8 is the borrow

   always_comb begin
      acc_nx = acc;
      c_nx   = carry;
      case (op.code)
         OP_MOVAI:  acc_nx = i_instr.op1;
         OP_ADDAI:  {c_nx, acc_nx} = sum;
         OP_SUBBAI: {c_nx, acc_nx} = diff;
         OP_ANLAI:  acc_nx = acc & i_instr.op1;
         OP_ORLA:   acc_nx = acc | i_instr.op1;
         OP_XRLA:   acc_nx = acc ^ i_instr.op1;
         OP_INCA:   acc_nx = acc + 8'd1;   // carry untouched
         OP_DECA:   acc_nx = acc - 8'd1;
         OP_CPLA:   acc_nx = ~acc;
         OP_CLRA:   acc_nx = 8'd0;
         OP_RL:     acc_nx = {acc[6:0], acc[7]};
         OP_RLC:    {c_nx, acc_nx} = {acc, carry};
         OP_RRC:    {acc_nx, c_nx} = {carry, acc};
         OP_CLRC:   c_nx = 1'b0;
         OP_SETBC:  c_nx = 1'b1;
         default: begin
            if (op.g.grp == GRP_ADDAR) {c_nx, acc_nx} = sum;
            else if (op.g.grp == GRP_MOVAR) acc_nx = r_sel;
         end
      endcase
   end

   assign r_wr = (op.g.grp == GRP_MOVRA) || (op.g.grp == GRP_INCR) || (op.g.grp == GRP_DJNZR);
   assign r_nx = (op.g.grp == GRP_MOVRA) ? acc :
                 (op.g.grp == GRP_INCR)  ? r_sel + 8'd1 :
                                           r_dec;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         regs  <= '0;
         dptr  <= '0;
      end else if (i_instr_valid) begin
         acc   <= acc_nx;
         carry <= c_nx;
         if (r_wr) regs[op.g.rn] <= r_nx;
         if (op.code == OP_MOVDP) dptr <= {i_instr.op1, i_instr.op2};
      end
   end

   ////////////////////////////////////////
   // branches, target relative to next instruction

   always_comb begin
      case (op.code)
         OP_SJMP: taken = 1'b1;
         OP_JZ:   taken = (acc == 8'd0);
         OP_JNZ:  taken = (acc != 8'd0);
         OP_JC:   taken = carry;
         OP_JNC:  taken = ~carry;
         default: taken = (op.g.grp == GRP_DJNZR) && (r_dec != 8'd0);
      endcase
   end

   assign o_branch.taken  = taken;
   assign o_branch.target = i_instr.next_pc + {{(`CODE_AW - 8){i_instr.op1[7]}}, i_instr.op1};

   ////////////////////////////////////////
   // transmit handshake

   assign movx_tx    = (op.code == OP_MOVXDA) && (dptr == `TX_DPTR);
   assign o_tx.valid = (i_instr_valid | pend) & movx_tx;
   assign o_tx.data  = acc;   // acc frozen while the core waits

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) pend <= 1'b0;
      else pend <= o_tx.valid & ~i_tx_ready;
   end

   assign o_exec_done = (i_instr_valid & ~movx_tx) | (o_tx.valid & i_tx_ready);

endmodule

//--- src/fetch_decode.sv
`timescale 1ns/1ns
`include "mcu_params.svh"

module fetch_decode import mcu_pkg::*; (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  logic                i_load_done,
   input  logic [7:0]          i_code_data,
   input  logic                i_exec_done,
   input  branch_s             i_branch,
   output logic [`CODE_AW-1:0] o_fetch_addr,
   output instr_s              o_instr,
   output logic                o_instr_valid
);

   localparam logic [2:0] SM_FETCH = 3'd0;
   localparam logic [2:0] SM_DEC0  = 3'd1;
   localparam logic [2:0] SM_DEC1  = 3'd2;
   localparam logic [2:0] SM_DEC2  = 3'd3;
   localparam logic [2:0] SM_WAIT  = 3'd4;

   logic [2:0]          state;
   logic [`CODE_AW-1:0] pc;
   op_word_u            op_q;
   logic [7:0]          op1_q;
   logic [7:0]          op2_q;
   logic [1:0]          len;
   logic                last;   // final byte of the instruction on the bus

   function automatic logic [1:0] instr_len(op_word_u w);
      if (w.code == OP_MOVDP) return 2'd3;
      if (w.g.grp == GRP_DJNZR) return 2'd2;
      case (w.code)
         OP_MOVAI, OP_ADDAI, OP_SUBBAI, OP_ANLAI, OP_ORLA, OP_XRLA,
         OP_SJMP, OP_JZ, OP_JNZ, OP_JC, OP_JNC: return 2'd2;
         default: return 2'd1;
      endcase
   endfunction

   ////////////////////////////////////////
   // sequencer

   // opcode straight off the bus in decode0, latched after that
   assign len  = instr_len((state == SM_DEC0) ? op_word_u'(i_code_data) : op_q);
   assign last = (state == SM_DEC0 && len == 2'd1) ||
                 (state == SM_DEC1 && len == 2'd2) ||
                 (state == SM_DEC2);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state         <= SM_FETCH;
         pc            <= '0;
         o_instr_valid <= 1'b0;
      end else begin
         o_instr_valid <= last;
         case (state)
            SM_FETCH: if (i_load_done) state <= SM_DEC0;
            SM_DEC0, SM_DEC1, SM_DEC2: begin
               pc    <= pc + 1'b1;
               state <= last ? SM_WAIT : state + 3'd1;
            end
            SM_WAIT: if (i_exec_done) begin   // may stall on MOVX
               state <= SM_FETCH;
               pc    <= i_branch.taken ? i_branch.target : pc;
            end
            default: state <= SM_FETCH;
         endcase
      end
   end

   ////////////////////////////////////////
   // operand latches

   always_ff @(posedge i_clk) begin
      if (state == SM_DEC0) op_q.code <= i_code_data;
      if (state == SM_DEC1) op1_q <= i_code_data;
      if (state == SM_DEC2) op2_q <= i_code_data;
   end

   assign o_fetch_addr    = pc;
   assign o_instr.op      = op_q;
   assign o_instr.op1     = op1_q;
   assign o_instr.op2     = op2_q;
   assign o_instr.next_pc = pc;   // already past the last byte

endmodule

//--- src/mcu_params.svh
`ifndef MCU_PARAMS_SVH
`define MCU_PARAMS_SVH

// serial bit time in core clocks, short for simulation
`define CLKS_PER_BIT 8

// bytes taken from the serial port before the core is released
`define LOAD_BYTES 64

// MOVX @DPTR,A to this address goes out on the transmitter
`define TX_DPTR 16'h0201

// code memory address width, 1 KB
`define CODE_AW 10

`endif

//--- src/mcu_pkg.sv
`include "mcu_params.svh"

package mcu_pkg;

   // full-byte opcodes
   localparam logic [7:0] OP_INCA   = 8'h04;
   localparam logic [7:0] OP_RRC    = 8'h13;
   localparam logic [7:0] OP_DECA   = 8'h14;
   localparam logic [7:0] OP_RL     = 8'h23;
   localparam logic [7:0] OP_ADDAI  = 8'h24;
   localparam logic [7:0] OP_RLC    = 8'h33;
   localparam logic [7:0] OP_JC     = 8'h40;
   localparam logic [7:0] OP_ORLA   = 8'h44;  // orl a,#imm
   localparam logic [7:0] OP_JNC    = 8'h50;
   localparam logic [7:0] OP_ANLAI  = 8'h54;
   localparam logic [7:0] OP_JZ     = 8'h60;
   localparam logic [7:0] OP_XRLA   = 8'h64;  // xrl a,#imm
   localparam logic [7:0] OP_JNZ    = 8'h70;
   localparam logic [7:0] OP_MOVAI  = 8'h74;
   localparam logic [7:0] OP_SJMP   = 8'h80;
   localparam logic [7:0] OP_MOVDP  = 8'h90;  // mov dptr,#imm16
   localparam logic [7:0] OP_SUBBAI = 8'h94;
   localparam logic [7:0] OP_CLRC   = 8'hC3;
   localparam logic [7:0] OP_SETBC  = 8'hD3;
   localparam logic [7:0] OP_CLRA   = 8'hE4;
   localparam logic [7:0] OP_MOVXDA = 8'hF0;  // movx @dptr,a
   localparam logic [7:0] OP_CPLA   = 8'hF4;

   // register instructions, matched on the upper five bits
   localparam logic [4:0] GRP_INCR  = 5'h01;
   localparam logic [4:0] GRP_ADDAR = 5'h05;
   localparam logic [4:0] GRP_DJNZR = 5'h1B;
   localparam logic [4:0] GRP_MOVAR = 5'h1D;
   localparam logic [4:0] GRP_MOVRA = 5'h1F;

   typedef struct packed {
      logic [4:0] grp;
      logic [2:0] rn;   // working register index
   } op_grp_s;

   typedef union packed {
      logic [7:0] code;
      op_grp_s    g;
   } op_word_u;

   typedef struct packed {
      op_word_u            op;
      logic [7:0]          op1;      // immediate, rel or dptr high
      logic [7:0]          op2;      // dptr low
      logic [`CODE_AW-1:0] next_pc;
   } instr_s;

   typedef struct packed {
      logic                taken;
      logic [`CODE_AW-1:0] target;
   } branch_s;

   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } tx_req_s;

endpackage

//--- src/mcu_top.sv
`timescale 1ns/1ns
`include "mcu_params.svh"

module mcu_top import mcu_pkg::*; (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  logic                i_uart_rx,
   input  logic [7:0]          i_code_data,
   output logic                o_uart_tx,
   output logic                o_code_wr,
   output logic [`CODE_AW-1:0] o_code_addr,
   output logic [7:0]          o_code_data
);

   logic [7:0]          rx_byte;
   logic                rx_valid;
   logic                load_done;
   logic [`CODE_AW-1:0] fetch_addr;
   instr_s              instr;
   logic                instr_valid;
   logic                exec_done;
   branch_s             branch;
   tx_req_s             tx_req;
   logic                tx_ready;

   // serial loader
   uart_rx u_rx (.i_clk, .i_nrst, .i_rx(i_uart_rx), .o_byte(rx_byte), .o_byte_valid(rx_valid));

   code_loader u_loader (.i_clk, .i_nrst, .i_byte(rx_byte), .i_byte_valid(rx_valid),
      .i_fetch_addr(fetch_addr), .o_code_wr, .o_code_addr, .o_code_data,
      .o_load_done(load_done));

   // core
   fetch_decode u_fetch (.i_clk, .i_nrst, .i_load_done(load_done), .i_code_data,
      .i_exec_done(exec_done), .i_branch(branch), .o_fetch_addr(fetch_addr),
      .o_instr(instr), .o_instr_valid(instr_valid));

   execute u_exec (.i_clk, .i_nrst, .i_instr(instr), .i_instr_valid(instr_valid),
      .i_tx_ready(tx_ready), .o_exec_done(exec_done), .o_branch(branch), .o_tx(tx_req));

   uart_tx u_tx (.i_clk, .i_nrst, .i_tx(tx_req), .o_tx_ready(tx_ready), .o_uart_tx);

endmodule

//--- src/uart_rx.sv
`timescale 1ns/1ns
`include "mcu_params.svh"

module uart_rx (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_rx,
   output logic [7:0] o_byte,
   output logic       o_byte_valid
);

   localparam int CW = $clog2(`CLKS_PER_BIT);
   localparam logic [1:0] SM_IDLE  = 2'd0;
   localparam logic [1:0] SM_START = 2'd1;
   localparam logic [1:0] SM_RECV  = 2'd2;
   localparam logic [1:0] SM_STOP  = 2'd3;

   logic          rx_s;
   logic [1:0]    state;
   logic [CW-1:0] cnt;
   logic          half;
   logic          full;
   logic [7:0]    shift;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) rx_s <= 1'b1;   // line idles high
      else rx_s <= i_rx;
   end

   assign half = (cnt == CW'(`CLKS_PER_BIT / 2 - 1));
   assign full = (cnt == CW'(`CLKS_PER_BIT - 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= SM_IDLE;
         cnt   <= '0;
      end else begin
         cnt <= cnt + 1'b1;
         case (state)
            SM_IDLE: begin
               cnt <= '0;
               if (!rx_s) state <= SM_START;
            end
            SM_START: if (half) begin
               cnt   <= '0;
               state <= rx_s ? SM_IDLE : SM_RECV;   // high again means a glitch
            end
            SM_RECV: if (full) begin
               cnt <= '0;
               if (shift[0]) state <= SM_STOP;   // marker reached the bottom
            end
            SM_STOP: if (full) begin
               cnt   <= '0;
               state <= SM_IDLE;
            end
         endcase
      end
   end

   // lsb first, marker bit falls out on the eighth sample
   always_ff @(posedge i_clk) begin
      if (state == SM_START && half) shift <= 8'h80;
      else if (state == SM_RECV && full) shift <= {rx_s, shift[7:1]};
   end

   assign o_byte       = shift;
   assign o_byte_valid = (state == SM_STOP) && full;   // middle of stop bit

endmodule

//--- src/uart_tx.sv
`timescale 1ns/1ns
`include "mcu_params.svh"

module uart_tx import mcu_pkg::*; (
   input  logic    i_clk,
   input  logic    i_nrst,
   input  tx_req_s i_tx,
   output logic    o_tx_ready,
   output logic    o_uart_tx
);

   localparam int CW = $clog2(`CLKS_PER_BIT);
   localparam logic [1:0] SM_IDLE  = 2'd0;
   localparam logic [1:0] SM_START = 2'd1;
   localparam logic [1:0] SM_SEND  = 2'd2;

   logic [1:0]    state;
   logic [CW-1:0] cnt;
   logic [3:0]    nbit;    // data bits plus the stop bit
   logic [7:0]    shift;
   logic          tick;    // end of a bit time

   assign tick       = (cnt == CW'(`CLKS_PER_BIT - 1));
   assign o_tx_ready = (state == SM_IDLE);
   assign o_uart_tx  = (state == SM_IDLE)  ? 1'b1 :
                       (state == SM_START) ? 1'b0 :
                                             shift[0];

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= SM_IDLE;
         cnt   <= '0;
         nbit  <= '0;
      end else begin
         cnt <= (state == SM_IDLE || tick) ? '0 : cnt + 1'b1;
         case (state)
            SM_IDLE: if (i_tx.valid) state <= SM_START;
            SM_START: if (tick) begin
               state <= SM_SEND;
               nbit  <= '0;
            end
            SM_SEND: if (tick) begin
               nbit <= nbit + 1'b1;
               if (nbit == 4'd8) state <= SM_IDLE;   // stop bit done
            end
            default: state <= SM_IDLE;
         endcase
      end
   end

   // ones fill in from the top, so the ninth bit is the stop bit
   always_ff @(posedge i_clk) begin
      if (o_tx_ready && i_tx.valid) shift <= i_tx.data;
      else if (state == SM_SEND && tick) shift <= {1'b1, shift[7:1]};
   end

endmodule
